// File: src/ctrl_pkg.sv
package ctrl_pkg;

	localparam int NUM_PLAYERS = 2;
	localparam int NUM_BUTTONS = 5; // width of one player vector

	// player vector bit positions, same order as host joystick
	localparam int BIT_RIGHT = 0;
	localparam int BIT_LEFT  = 1;
	localparam int BIT_DOWN  = 2;
	localparam int BIT_UP    = 3;
	localparam int BIT_FIRE  = 4;

	// ps/2 set 2 make codes
	typedef enum logic [7:0] {
		KEY_P1_START = 8'h05, // F1
		KEY_P2_START = 8'h06, // F2
		KEY_P2_FIRE  = 8'h14, // ctrl
		KEY_P2_DOWN  = 8'h1B, // S
		KEY_P2_LEFT  = 8'h1C, // A
		KEY_P2_UP    = 8'h1D, // W
		KEY_P2_RIGHT = 8'h23, // D
		KEY_P1_FIRE  = 8'h29, // space
		KEY_P1_LEFT  = 8'h6B,
		KEY_P1_DOWN  = 8'h72,
		KEY_P1_RIGHT = 8'h74,
		KEY_P1_UP    = 8'h75,
		KEY_COIN     = 8'h76  // ESC
	} key_code_t;

endpackage

// File: src/host_pkg.sv
package host_pkg;

	// wishbone word addresses
	typedef enum logic [1:0] {
		REG_CONFIG   = 2'd0, // r/w
		REG_JOY0     = 2'd1, // r/w, low 5 bits used
		REG_JOY1     = 2'd2, // r/w, low 5 bits used
		REG_CONTROLS = 2'd3  // read only
	} reg_addr_t;

	// CONFIG bits
	localparam int CFG_SOFT_RESET = 0;
	localparam int CFG_ROTATE     = 1;

	localparam int REG_WIDTH = 8;

endpackage

// File: src/host_regs.sv
`timescale 1ns/1ps

module host_regs #(
	parameter int num_players = 2
) (
	input  logic                       clock_24,
	input  logic                       reset,
	input  logic                       wb_cyc,
	input  logic                       wb_stb,
	input  logic                       wb_we,
	input  logic [1:0]                 wb_adr,
	input  logic [7:0]                 wb_dat_w,
	output logic [7:0]                 wb_dat_r,
	output logic                       wb_ack,
	input  logic [7:0]                 controls,
	output logic [num_players*8-1:0]   joy,
	output logic                       rotate,
	output logic                       game_reset
);

	localparam int W = host_pkg::REG_WIDTH;

	logic [W-1:0]             config_q;
	logic [num_players*W-1:0] joy_q;
	logic                     access;
	host_pkg::reg_addr_t      addr;

	assign access = wb_cyc & wb_stb & ~wb_ack; // new access this cycle
	assign addr   = host_pkg::reg_addr_t'(wb_adr);

	always_ff @(posedge clock_24) begin
		if (reset) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= access;
		end
	end

	// writes land on the edge that raises ack
	always_ff @(posedge clock_24) begin
		if (reset) begin
			config_q <= '0;
			joy_q    <= '0;
		end else if (access && wb_we) begin
			case (addr)
				host_pkg::REG_CONFIG: config_q     <= wb_dat_w;
				host_pkg::REG_JOY0:   joy_q[0 +: W] <= wb_dat_w;
				host_pkg::REG_JOY1:   joy_q[W +: W] <= wb_dat_w;
				default: ;                             // controls read only
			endcase
		end
	end

	// read data held while ack is high
	always_ff @(posedge clock_24) begin
		if (access) begin
			case (addr)
				host_pkg::REG_CONFIG: wb_dat_r <= config_q;
				host_pkg::REG_JOY0:   wb_dat_r <= joy_q[0 +: W];
				host_pkg::REG_JOY1:   wb_dat_r <= joy_q[W +: W];
				default:              wb_dat_r <= controls;
			endcase
		end
	end

	always_ff @(posedge clock_24) begin
		game_reset <= reset | config_q[host_pkg::CFG_SOFT_RESET];
	end

	assign joy    = joy_q;
	assign rotate = config_q[host_pkg::CFG_ROTATE];

	a_ack_needs_request: assert property (
		@(posedge clock_24) disable iff (reset)
		$rose(wb_ack) |-> $past(wb_cyc && wb_stb)
	);

endmodule

// File: src/key_decoder.sv
`timescale 1ns/1ps

module key_decoder #(
	parameter int num_players = 2
) (
	input  logic                                      clock_24,
	input  logic                                      reset,
	input  logic                                      key_strobe,
	input  logic                                      key_pressed,
	input  logic [7:0]                                key_code,
	output logic [num_players*ctrl_pkg::NUM_BUTTONS-1:0] kb_buttons,
	output logic [num_players-1:0]                    kb_start,
	output logic                                      kb_coin
);

	localparam int P2 = ctrl_pkg::NUM_BUTTONS; // player 2 base index

	always_ff @(posedge clock_24) begin
		if (reset) begin
			kb_buttons <= '0;
			kb_start   <= '0;
			kb_coin    <= 1'b0;
		end else if (key_strobe) begin
			case (key_code)
				ctrl_pkg::KEY_P1_UP:    kb_buttons[ctrl_pkg::BIT_UP]         <= key_pressed;
				ctrl_pkg::KEY_P1_DOWN:  kb_buttons[ctrl_pkg::BIT_DOWN]       <= key_pressed;
				ctrl_pkg::KEY_P1_LEFT:  kb_buttons[ctrl_pkg::BIT_LEFT]       <= key_pressed;
				ctrl_pkg::KEY_P1_RIGHT: kb_buttons[ctrl_pkg::BIT_RIGHT]      <= key_pressed;
				ctrl_pkg::KEY_P1_FIRE:  kb_buttons[ctrl_pkg::BIT_FIRE]       <= key_pressed;
				ctrl_pkg::KEY_P2_UP:    kb_buttons[P2 + ctrl_pkg::BIT_UP]    <= key_pressed;
				ctrl_pkg::KEY_P2_DOWN:  kb_buttons[P2 + ctrl_pkg::BIT_DOWN]  <= key_pressed;
				ctrl_pkg::KEY_P2_LEFT:  kb_buttons[P2 + ctrl_pkg::BIT_LEFT]  <= key_pressed;
				ctrl_pkg::KEY_P2_RIGHT: kb_buttons[P2 + ctrl_pkg::BIT_RIGHT] <= key_pressed;
				ctrl_pkg::KEY_P2_FIRE:  kb_buttons[P2 + ctrl_pkg::BIT_FIRE]  <= key_pressed;
				ctrl_pkg::KEY_P1_START: kb_start[0]                          <= key_pressed;
				ctrl_pkg::KEY_P2_START: kb_start[1]                          <= key_pressed;
				ctrl_pkg::KEY_COIN:     kb_coin                              <= key_pressed;
				default: ; // unknown code, ignore
			endcase
		end
	end

endmodule

// File: src/player_input.sv
`timescale 1ns/1ps

module player_input (
	input  logic                             clock_24,
	input  logic                             reset,
	input  logic [ctrl_pkg::NUM_BUTTONS-1:0] joy,
	input  logic [ctrl_pkg::NUM_BUTTONS-1:0] kb,
	input  logic                             rotate,
	output logic [ctrl_pkg::NUM_BUTTONS-1:0] mapped
);

	logic [ctrl_pkg::NUM_BUTTONS-1:0] merged;
	logic [ctrl_pkg::NUM_BUTTONS-1:0] rotated;

	assign merged = joy | kb;

	// cabinet turned a quarter, fire untouched
	always_comb begin
		rotated = merged;
		if (rotate) begin
			rotated[ctrl_pkg::BIT_UP]    = merged[ctrl_pkg::BIT_LEFT];
			rotated[ctrl_pkg::BIT_DOWN]  = merged[ctrl_pkg::BIT_RIGHT];
			rotated[ctrl_pkg::BIT_LEFT]  = merged[ctrl_pkg::BIT_DOWN];
			rotated[ctrl_pkg::BIT_RIGHT] = merged[ctrl_pkg::BIT_UP];
		end
	end

	always_ff @(posedge clock_24) begin
		if (reset) begin
			mapped <= '0;
		end else begin
			mapped <= rotated;
		end
	end

endmodule

// File: src/control_merge.sv
`timescale 1ns/1ps

module control_merge #(
	parameter int num_players = 2,
	parameter int coin_hold   = 16
) (
	input  logic                                          clock_24,
	input  logic                                          reset,
	input  logic [num_players*ctrl_pkg::NUM_BUTTONS-1:0] mapped,
	input  logic [num_players-1:0]                        kb_start,
	input  logic                                          kb_coin,
	output logic                                          game_up,
	output logic                                          game_down,
	output logic                                          game_left,
	output logic                                          game_right,
	output logic                                          game_fire,
	output logic [num_players-1:0]                        game_start,
	output logic                                          game_coin
);

	localparam int NB    = ctrl_pkg::NUM_BUTTONS;
	localparam int CNT_W = $clog2(coin_hold + 1);

	logic [NB-1:0]    any_player;
	logic [CNT_W-1:0] coin_cnt;
	logic             coin_prev;

	always_comb begin
		any_player = '0;
		for (int p = 0; p < num_players; p++) begin
			any_player = any_player | mapped[p*NB +: NB];
		end
	end

	always_ff @(posedge clock_24) begin
		if (reset) begin
			game_up    <= 1'b0;
			game_down  <= 1'b0;
			game_left  <= 1'b0;
			game_right <= 1'b0;
			game_fire  <= 1'b0;
			game_start <= '0;
			game_coin  <= 1'b0;
			coin_cnt   <= '0;
			coin_prev  <= 1'b0;
		end else begin
			game_up    <= any_player[ctrl_pkg::BIT_UP];
			game_down  <= any_player[ctrl_pkg::BIT_DOWN];
			game_left  <= any_player[ctrl_pkg::BIT_LEFT];
			game_right <= any_player[ctrl_pkg::BIT_RIGHT];
			game_fire  <= any_player[ctrl_pkg::BIT_FIRE];
			game_start <= kb_start;
			coin_prev  <= kb_coin;
			if (kb_coin && !coin_prev) begin
				coin_cnt <= CNT_W'(coin_hold - 1); // first cycle counted by kb_coin
			end else if (coin_cnt != '0) begin
				coin_cnt <= coin_cnt - 1'b1;
			end
			game_coin <= kb_coin | (coin_cnt != '0);
		end
	end

	a_coin_min_width: assert property (
		@(posedge clock_24) disable iff (reset)
		$rose(game_coin) |-> game_coin [* coin_hold]
	);

endmodule

// File: src/sigma_delta_dac.sv
`timescale 1ns/1ps

module sigma_delta_dac #(
	parameter int dac_bits = 16
) (
	input  logic                       clock_24,
	input  logic                       reset,
	input  logic signed [dac_bits-1:0] sample,
	output logic                       bit_out
);

	logic [dac_bits-1:0] offset;
	logic [dac_bits-1:0] acc;
	logic [dac_bits:0]   sum;

	assign offset = {~sample[dac_bits-1], sample[dac_bits-2:0]}; // two's complement to offset binary
	assign sum    = {1'b0, acc} + {1'b0, offset};

	always_ff @(posedge clock_24) begin
		if (reset) begin
			acc     <= '0;
			bit_out <= 1'b0;
		end else begin
			acc     <= sum[dac_bits-1:0];
			bit_out <= sum[dac_bits]; // carry is the density
		end
	end

endmodule

// File: src/arcade_io_top.sv
`timescale 1ns/1ps

module arcade_io_top #(
	parameter int num_players = ctrl_pkg::NUM_PLAYERS,
	parameter int coin_hold   = 16,
	parameter int dac_bits    = 16
) (
	input  logic                       clock_24,
	input  logic                       reset,
	input  logic                       wb_cyc,
	input  logic                       wb_stb,
	input  logic                       wb_we,
	input  logic [1:0]                 wb_adr,
	input  logic [7:0]                 wb_dat_w,
	output logic [7:0]                 wb_dat_r,
	output logic                       wb_ack,
	input  logic                       key_strobe,
	input  logic                       key_pressed,
	input  logic [7:0]                 key_code,
	input  logic signed [dac_bits-1:0] audio,
	output logic                       game_up,
	output logic                       game_down,
	output logic                       game_left,
	output logic                       game_right,
	output logic                       game_fire,
	output logic [num_players-1:0]     game_start,
	output logic                       game_coin,
	output logic                       game_reset,
	output logic                       audio_l,
	output logic                       audio_r
);

	localparam int NB = ctrl_pkg::NUM_BUTTONS;

	logic [num_players*8-1:0]  joy;
	logic                      rotate;
	logic [num_players*NB-1:0] kb_buttons;
	logic [num_players-1:0]    kb_start;
	logic                      kb_coin;
	logic [num_players*NB-1:0] mapped;

	host_regs #(
		.num_players (num_players)
	) i_host_regs (
		.clock_24   (clock_24),
		.reset      (reset),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.wb_dat_r   (wb_dat_r),
		.wb_ack     (wb_ack),
		.controls   ({game_coin, game_start[1], game_start[0], game_fire,
			game_up, game_down, game_left, game_right}),
		.joy        (joy),
		.rotate     (rotate),
		.game_reset (game_reset)
	);

	key_decoder #(
		.num_players (num_players)
	) i_key_decoder (
		.clock_24    (clock_24),
		.reset       (reset),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.kb_buttons  (kb_buttons),
		.kb_start    (kb_start),
		.kb_coin     (kb_coin)
	);

	for (genvar p = 0; p < num_players; p++) begin : g_player
		player_input i_player_input (
			.clock_24 (clock_24),
			.reset    (reset),
			.joy      (joy[p*8 +: NB]), // upper joystick bits unused
			.kb       (kb_buttons[p*NB +: NB]),
			.rotate   (rotate),
			.mapped   (mapped[p*NB +: NB])
		);
	end

	control_merge #(
		.num_players (num_players),
		.coin_hold   (coin_hold)
	) i_control_merge (
		.clock_24   (clock_24),
		.reset      (reset),
		.mapped     (mapped),
		.kb_start   (kb_start),
		.kb_coin    (kb_coin),
		.game_up    (game_up),
		.game_down  (game_down),
		.game_left  (game_left),
		.game_right (game_right),
		.game_fire  (game_fire),
		.game_start (game_start),
		.game_coin  (game_coin)
	);

	sigma_delta_dac #(
		.dac_bits (dac_bits)
	) i_sigma_delta_dac (
		.clock_24 (clock_24),
		.reset    (reset),
		.sample   (audio),
		.bit_out  (audio_l)
	);

	assign audio_r = audio_l; // mono

endmodule

// File: tb/tb_arcade_io_top.sv
`timescale 1ns/1ps

module tb_arcade_io_top;

	localparam int NUM_PLAYERS = 2;
	localparam int COIN_HOLD   = 16;
	localparam int DAC_BITS    = 16;
	localparam int MAX_CYCLES  = 150000;

	logic                       clock_24;
	logic                       reset;
	logic                       wb_cyc;
	logic                       wb_stb;
	logic                       wb_we;
	logic [1:0]                 wb_adr;
	logic [7:0]                 wb_dat_w;
	logic [7:0]                 wb_dat_r;
	logic                       wb_ack;
	logic                       key_strobe;
	logic                       key_pressed;
	logic [7:0]                 key_code;
	logic signed [DAC_BITS-1:0] audio;
	logic                       game_up;
	logic                       game_down;
	logic                       game_left;
	logic                       game_right;
	logic                       game_fire;
	logic [NUM_PLAYERS-1:0]     game_start;
	logic                       game_coin;
	logic                       game_reset;
	logic                       audio_l;
	logic                       audio_r;

	logic [31:0] lfsr;
	int          errors;
	int          cycles = 0;
	logic [7:0]  m_config;
	logic [7:0]  m_joy [NUM_PLAYERS];
	logic [4:0]  m_kb [NUM_PLAYERS];
	logic [1:0]  m_start;
	logic [7:0]  rd_data;
	logic        reset_at_ack; // game_reset seen on the ack cycle
	logic [7:0]  key_tab [12]; // index is the state slot

	arcade_io_top #(
		.num_players (NUM_PLAYERS),
		.coin_hold   (COIN_HOLD),
		.dac_bits    (DAC_BITS)
	) i_arcade_io_top (
		.clock_24    (clock_24),
		.reset       (reset),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.audio       (audio),
		.game_up     (game_up),
		.game_down   (game_down),
		.game_left   (game_left),
		.game_right  (game_right),
		.game_fire   (game_fire),
		.game_start  (game_start),
		.game_coin   (game_coin),
		.game_reset  (game_reset),
		.audio_l     (audio_l),
		.audio_r     (audio_r)
	);

	initial begin
		clock_24 = 1'b0;
		forever #2 clock_24 = ~clock_24;
	end

	always @(posedge clock_24) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run stopped after %0d cycles without finishing", cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	function automatic logic random_bit();
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		return lfsr[0];
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], random_bit()};
		end
		return value;
	endfunction

	// quarter turn, fire stays
	function automatic logic [4:0] rotate_dirs(input logic [4:0] v, input logic rot);
		logic [4:0] r;
		r = v;
		if (rot) begin
			r[3] = v[1]; // up from left
			r[2] = v[0]; // down from right
			r[1] = v[2]; // left from down
			r[0] = v[3]; // right from up
		end
		return r;
	endfunction

	function automatic logic [4:0] expected_buttons();
		logic [4:0] b;
		b = '0;
		for (int p = 0; p < NUM_PLAYERS; p++) begin
			b = b | rotate_dirs(m_joy[p][4:0] | m_kb[p], m_config[1]);
		end
		return b;
	endfunction

	function automatic int key_slot(input logic [7:0] code);
		for (int s = 0; s < 12; s++) begin
			if (key_tab[s] == code) begin
				return s;
			end
		end
		return -1;
	endfunction

	function automatic void update_key_model(input logic [7:0] code, input logic pressed);
		int slot;
		slot = key_slot(code);
		if (slot >= 0 && slot < 5) begin
			m_kb[0][slot] = pressed;
		end else if (slot >= 5 && slot < 10) begin
			m_kb[1][slot-5] = pressed;
		end else if (slot >= 10) begin
			m_start[slot-10] = pressed;
		end
	endfunction

	task automatic report_error(input string msg);
		errors++;
		$display("FAIL %0t: %s", $time, msg);
	endtask

	task automatic check_outputs(input string where);
		logic [4:0] want;
		logic [4:0] got;
		want = expected_buttons();
		got  = {game_fire, game_up, game_down, game_left, game_right};
		if (got !== want) begin
			report_error($sformatf("%s: buttons %b, expected %b", where, got, want));
		end
		if (game_start !== m_start) begin
			report_error($sformatf("%s: start %b, expected %b", where, game_start, m_start));
		end
	endtask

	// called and returns on a falling edge, one cycle after the ack cycle
	task automatic wb_access(input logic we, input logic [1:0] adr, input logic [7:0] data);
		int waited;
		waited   = 0;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = data;
		do begin
			@(negedge clock_24);
			waited++;
		end while (!wb_ack && waited < 16);
		if (!wb_ack) begin
			errors++;
			$display("error: no wb_ack within 16 cycles for address %0d", adr);
		end else if (waited != 1) begin
			report_error($sformatf("wb_ack came after %0d cycles", waited));
		end
		rd_data      = wb_dat_r;
		reset_at_ack = game_reset;
		@(negedge clock_24); // stb still held through the ack cycle
		if (wb_ack !== 1'b0) begin
			report_error("wb_ack high for more than one cycle");
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic reg_write(input logic [1:0] adr, input logic [7:0] data);
		wb_access(1'b1, adr, data);
		case (adr)
			2'd0: m_config = data;
			2'd1: m_joy[0] = data;
			2'd2: m_joy[1] = data;
			default: ;
		endcase
	endtask

	task automatic send_key(input logic [7:0] code, input logic pressed);
		key_strobe  = 1'b1;
		key_pressed = pressed;
		key_code    = code;
		@(negedge clock_24);
		key_strobe  = 1'b0;
		key_code    = 8'h00;
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (8) @(negedge clock_24);
		if ({wb_ack, game_up, game_down, game_left, game_right, game_fire, game_start,
			game_coin, audio_l} !== '0) begin
			report_error("outputs not low in reset");
		end
		if (game_reset !== 1'b1) begin
			report_error("game_reset low in reset");
		end
		reset      = 1'b0;
		m_config   = '0;
		m_joy[0]   = '0;
		m_joy[1]   = '0;
		m_kb[0]    = '0;
		m_kb[1]    = '0;
		m_start    = '0;
		@(negedge clock_24);
	endtask

	initial begin
		logic [1:0]  adr;
		logic [7:0]  data;
		logic [7:0]  code;
		logic        pressed;
		logic [15:0] sample;
		int          ones;
		int          high_cycles;
		int          waited;

		reset       = 1'b1;
		wb_cyc      = 1'b0;
		wb_stb      = 1'b0;
		wb_we       = 1'b0;
		wb_adr      = '0;
		wb_dat_w    = '0;
		key_strobe  = 1'b0;
		key_pressed = 1'b0;
		key_code    = '0;
		audio       = '0;
		lfsr        = 32'd93130;
		errors      = 0;
		key_tab[0]  = 8'h74; // p1 right
		key_tab[1]  = 8'h6B;
		key_tab[2]  = 8'h72;
		key_tab[3]  = 8'h75;
		key_tab[4]  = 8'h29;
		key_tab[5]  = 8'h23; // p2 right
		key_tab[6]  = 8'h1C;
		key_tab[7]  = 8'h1B;
		key_tab[8]  = 8'h1D;
		key_tab[9]  = 8'h14;
		key_tab[10] = 8'h05; // starts
		key_tab[11] = 8'h06;
		apply_reset();

		for (int i = 0; i < 20; i++) begin
			adr  = 2'(random_bits(8) % 3);
			data = 8'(random_bits(8));
			reg_write(adr, data);
			wb_access(1'b0, adr, 8'h00);
			if (rd_data !== data) begin
				report_error($sformatf("reg %0d read %h, wrote %h", adr, rd_data, data));
			end
			repeat (3) @(negedge clock_24);
			wb_access(1'b0, 2'd3, 8'h00);
			if (rd_data !== {1'b0, m_start, expected_buttons()}) begin
				report_error($sformatf("controls read %h", rd_data));
			end
		end

		for (int rot = 0; rot < 2; rot++) begin
			reg_write(2'd0, 8'(rot << 1));
			for (int i = 0; i < 16; i++) begin
				for (int p = 0; p < NUM_PLAYERS; p++) begin
					reg_write(2'(p + 1), 8'(random_bits(8)));
					@(negedge clock_24); // third edge after the write edge
					check_outputs($sformatf("joy%0d rot%0d", p, rot));
				end
			end
		end
		reg_write(2'd1, 8'h00);
		reg_write(2'd2, 8'h00);

		for (int i = 0; i < 200; i++) begin
			if (random_bit()) begin
				code = key_tab[random_bits(8) % 12];
			end else begin
				do begin
					code = 8'(random_bits(8));
				end while (key_slot(code) >= 0 || code == 8'h76);
			end
			pressed = random_bit();
			send_key(code, pressed);
			update_key_model(code, pressed);
			@(negedge clock_24);
			if (game_start !== m_start) begin
				report_error($sformatf("start %b two edges after key %h", game_start, code));
			end
			@(negedge clock_24);
			check_outputs($sformatf("key %h", code));
		end

		// short coin press
		send_key(8'h76, 1'b1);
		if (game_coin !== 1'b0) begin
			report_error("game_coin rose one edge after strobe");
		end
		send_key(8'h76, 1'b0);
		high_cycles = 0;
		waited      = 0;
		while (game_coin && waited < 4 * COIN_HOLD) begin
			high_cycles++;
			waited++;
			@(negedge clock_24);
		end
		if (high_cycles != COIN_HOLD) begin
			report_error($sformatf("coin pulse %0d cycles, expected %0d", high_cycles, COIN_HOLD));
		end
		repeat (4) @(negedge clock_24);

		// long coin hold
		high_cycles = 0;
		send_key(8'h76, 1'b1);
		for (int k = 0; k < 40; k++) begin
			@(negedge clock_24);
			if (game_coin) begin
				high_cycles++;
			end
		end
		send_key(8'h76, 1'b0);
		if (game_coin !== 1'b1) begin
			report_error("game_coin fell one edge after release");
		end
		high_cycles++;
		@(negedge clock_24);
		if (game_coin !== 1'b0) begin
			report_error("game_coin still high two edges after release");
		end
		if (high_cycles < COIN_HOLD) begin
			report_error($sformatf("held coin high only %0d cycles", high_cycles));
		end

		reg_write(2'd0, m_config | 8'h01);
		if (reset_at_ack !== 1'b0 || game_reset !== 1'b1) begin
			report_error("game_reset not raised one cycle after soft reset write");
		end
		reg_write(2'd0, m_config & 8'hFE);
		if (reset_at_ack !== 1'b1 || game_reset !== 1'b0) begin
			report_error("game_reset not lowered after soft reset clear");
		end
		reg_write(2'd1, 8'h1F);
		apply_reset();
		if (game_reset !== 1'b0) begin
			report_error("game_reset high after reset release");
		end
		check_outputs("after reset");
		wb_access(1'b0, 2'd1, 8'h00);
		if (rd_data !== 8'h00) begin
			report_error($sformatf("JOY0 %h after reset", rd_data));
		end

		for (int n = 0; n < 2; n++) begin
			sample = 16'(random_bits(16));
			audio  = sample;
			repeat (4) @(negedge clock_24);
			ones = 0;
			repeat (65536) begin
				@(negedge clock_24);
				if (audio_l) begin
					ones++;
				end
				if (audio_r !== audio_l) begin
					report_error("audio_r differs from audio_l");
				end
			end
			if (ones != int'(sample ^ 16'h8000)) begin
				report_error($sformatf("dac sample %h gave %0d ones", sample, ones));
			end
		end

		$display("errors counted: %0d", errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: sim.f
src/ctrl_pkg.sv
src/host_pkg.sv
src/host_regs.sv
src/key_decoder.sv
src/player_input.sv
src/control_merge.sv
src/sigma_delta_dac.sv
src/arcade_io_top.sv
tb/tb_arcade_io_top.sv
